//--- source/l2_cfg_pkg.sv
package l2_cfg_pkg;

    // line geometry
    localparam int OFFSET_WIDTH = 2;
    localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;
    localparam int LINE_BITS    = LINE_WORDS * 32;

    // axi len field of a full line burst
    localparam logic [7:0] BURST_LEN = 8'(LINE_WORDS - 1);

    // write path states decoded by the arbiter
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        DMA_AW = 4'd1,  // uncached address phase
        DMA_W  = 4'd2,  // uncached single beat
        DMA_R  = 4'd3,  // uncached response
        WRT_W  = 4'd4   // line buffer draining
    } wr_state_t;

endpackage

//--- source/l2_bus_pkg.sv
package l2_bus_pkg;

    // write request as the cache presents it
    typedef struct packed {
        logic [31:0]                      addr;
        logic [l2_cfg_pkg::LINE_BITS-1:0] data;
    } line_req_t;

    // memory write port with address, data and response strobes
    typedef struct packed {
        logic [31:0] waddr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [7:0]  len;
        logic        wvalid;   // address valid
        logic        wwvalid;  // data valid
        logic        wlast;
        logic        bready;
    } mem_wr_t;

    // what memory sends back
    typedef struct packed {
        logic waddr_ok;
        logic wready;
        logic bvalid;
    } mem_wr_rsp_t;

endpackage

//--- source/l2_write_ctrl.sv
`timescale 1ns/10ps

module l2_write_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_w,
    input  logic                    dma_sign,
    input  logic                    busy,
    input  l2_bus_pkg::mem_wr_rsp_t mem_rsp,
    output l2_cfg_pkg::wr_state_t   crt
);

    l2_cfg_pkg::wr_state_t nxt;

    always_comb begin
        nxt = crt;
        case (crt)
            l2_cfg_pkg::IDLE: begin
                // a draining line goes first to keep write order
                if (busy) begin
                    nxt = l2_cfg_pkg::WRT_W;
                end else if (req_w && dma_sign) begin
                    nxt = l2_cfg_pkg::DMA_AW;
                end
            end
            l2_cfg_pkg::DMA_AW: begin
                if (mem_rsp.waddr_ok) begin
                    nxt = l2_cfg_pkg::DMA_W;
                end
            end
            l2_cfg_pkg::DMA_W: begin
                if (mem_rsp.wready) begin
                    nxt = l2_cfg_pkg::DMA_R;
                end
            end
            l2_cfg_pkg::DMA_R: begin
                if (mem_rsp.bvalid) begin
                    nxt = l2_cfg_pkg::IDLE;
                end
            end
            l2_cfg_pkg::WRT_W: begin
                if (!busy) begin
                    nxt = l2_cfg_pkg::IDLE;
                end
            end
            default: begin
                nxt = l2_cfg_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crt <= l2_cfg_pkg::IDLE;
        end else begin
            crt <= nxt;
        end
    end

    a_crt_legal: assert property (@(posedge clk) disable iff (rst)
        crt inside {l2_cfg_pkg::IDLE, l2_cfg_pkg::DMA_AW, l2_cfg_pkg::DMA_W,
                    l2_cfg_pkg::DMA_R, l2_cfg_pkg::WRT_W});

    // buffer cannot pick up a line while an uncached write owns the port
    a_dma_idle_buf: assert property (@(posedge clk) disable iff (rst)
        crt inside {l2_cfg_pkg::DMA_AW, l2_cfg_pkg::DMA_W, l2_cfg_pkg::DMA_R}
        |-> !busy);

endmodule

//--- source/write_buffer.sv
`timescale 1ns/10ps

module write_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    buf_req,
    input  l2_bus_pkg::line_req_t   buf_line,
    input  l2_bus_pkg::mem_wr_rsp_t buf_rsp,
    output logic                    buf_ok,
    output l2_bus_pkg::mem_wr_t     buf_wr,
    output logic                    busy
);

    typedef enum logic [1:0] {
        S_EMPTY,
        S_AW,
        S_W,
        S_B
    } buf_state_t;

    buf_state_t                          state;
    logic [l2_cfg_pkg::OFFSET_WIDTH-1:0] cnt;     // current beat
    logic                                last_q;  // current beat is the final one
    logic [31:0]                         addr_q;
    logic [l2_cfg_pkg::LINE_BITS-1:0]    line_q;
    logic                                accept;

    assign buf_ok = (state == S_EMPTY);
    assign accept = buf_ok && buf_req;
    assign busy   = !buf_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_EMPTY;
            cnt    <= '0;
            last_q <= 1'b0;
        end else begin
            case (state)
                S_EMPTY: begin
                    if (accept) begin
                        state <= S_AW;
                    end
                end
                S_AW: begin
                    if (buf_rsp.waddr_ok) begin
                        state  <= S_W;
                        cnt    <= '0;
                        last_q <= (l2_cfg_pkg::LINE_WORDS == 1);
                    end
                end
                S_W: begin
                    if (buf_rsp.wready) begin
                        if (last_q) begin
                            state  <= S_B;
                            last_q <= 1'b0;
                        end else begin
                            cnt    <= cnt + 1'b1;
                            last_q <= (int'(cnt) == l2_cfg_pkg::LINE_WORDS - 2);
                        end
                    end
                end
                S_B: begin
                    if (buf_rsp.bvalid) begin
                        state <= S_EMPTY;
                    end
                end
                default: begin
                    state <= S_EMPTY;
                end
            endcase
        end
    end

    // line is captured in the cycle it is accepted
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= buf_line.addr;
            line_q <= buf_line.data;
        end
    end

    always_comb begin
        buf_wr         = '0;                          // strb and len come from the arbiter
        buf_wr.waddr   = addr_q;                      // whole burst uses the line address
        buf_wr.wdata   = line_q[cnt*32 +: 32];        // lowest word first
        buf_wr.wvalid  = (state == S_AW);
        buf_wr.wwvalid = (state == S_W);
        buf_wr.wlast   = last_q;
        buf_wr.bready  = (state == S_B);
    end

    // registered last flag has to line up with the final beat
    a_wlast_beat: assert property (@(posedge clk) disable iff (rst)
        buf_wr.wlast |-> (state == S_W) && (int'(cnt) == l2_cfg_pkg::LINE_WORDS - 1));

endmodule

//--- source/write_arbiter.sv
`timescale 1ns/10ps

module write_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  l2_cfg_pkg::wr_state_t   crt,
    input  logic                    req_w,
    input  logic                    dma_sign,
    input  l2_bus_pkg::line_req_t   line,
    input  logic [3:0]              wstrb,
    input  l2_bus_pkg::mem_wr_rsp_t mem_rsp,
    input  l2_bus_pkg::mem_wr_t     buf_wr,
    input  logic                    buf_ok,
    output logic                    addr_ok_w,
    output logic                    buf_req,
    output l2_bus_pkg::line_req_t   buf_line,
    output l2_bus_pkg::mem_wr_t     mem_wr,
    output l2_bus_pkg::mem_wr_rsp_t buf_rsp
);

    always_comb begin
        addr_ok_w = 1'b0;
        buf_req   = 1'b0;
        buf_line  = '0;
        mem_wr    = '0;
        buf_rsp   = '0;
        case (crt)
            l2_cfg_pkg::IDLE,
            l2_cfg_pkg::WRT_W: begin
                // port belongs to the line buffer
                buf_req   = req_w && !dma_sign;
                buf_line  = line;
                addr_ok_w = buf_req && buf_ok;

                mem_wr       = buf_wr;
                mem_wr.len   = l2_cfg_pkg::BURST_LEN;
                mem_wr.wstrb = 4'hF;  // full line with all bytes

                buf_rsp = mem_rsp;
            end
            l2_cfg_pkg::DMA_AW: begin
                mem_wr.waddr  = line.addr;
                mem_wr.wdata  = line.data[31:0];
                mem_wr.wstrb  = wstrb;
                mem_wr.len    = 8'd0;
                mem_wr.wvalid = 1'b1;
            end
            l2_cfg_pkg::DMA_W: begin
                mem_wr.waddr   = line.addr;
                mem_wr.wdata   = line.data[31:0];  // single word from the low end of the line
                mem_wr.wstrb   = wstrb;
                mem_wr.len     = 8'd0;
                mem_wr.wwvalid = 1'b1;
                mem_wr.wlast   = 1'b1;
            end
            l2_cfg_pkg::DMA_R: begin
                addr_ok_w     = mem_rsp.bvalid;  // cache released on response
                mem_wr.wstrb  = wstrb;
                mem_wr.len    = 8'd0;
                mem_wr.bready = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // holds for both the buffer path and the uncached path
    a_wlast_with_data: assert property (@(posedge clk) disable iff (rst)
        mem_wr.wlast |-> mem_wr.wwvalid);

endmodule

//--- source/l2_write_top.sv
`timescale 1ns/10ps

module l2_write_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_w,
    input  logic                    dma_sign,
    input  l2_bus_pkg::line_req_t   line,
    input  logic [3:0]              wstrb,
    input  l2_bus_pkg::mem_wr_rsp_t mem_rsp,
    output logic                    addr_ok_w,
    output l2_bus_pkg::mem_wr_t     mem_wr
);

    l2_cfg_pkg::wr_state_t   crt;
    logic                    busy;
    logic                    buf_req;
    logic                    buf_ok;
    l2_bus_pkg::line_req_t   buf_line;
    l2_bus_pkg::mem_wr_t     buf_wr;
    l2_bus_pkg::mem_wr_rsp_t buf_rsp;

    l2_write_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req_w    (req_w),
        .dma_sign (dma_sign),
        .busy     (busy),
        .mem_rsp  (mem_rsp),
        .crt      (crt)
    );

    write_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .crt       (crt),
        .req_w     (req_w),
        .dma_sign  (dma_sign),
        .line      (line),
        .wstrb     (wstrb),
        .mem_rsp   (mem_rsp),
        .buf_wr    (buf_wr),
        .buf_ok    (buf_ok),
        .addr_ok_w (addr_ok_w),
        .buf_req   (buf_req),
        .buf_line  (buf_line),
        .mem_wr    (mem_wr),
        .buf_rsp   (buf_rsp)
    );

    write_buffer u_buf (
        .clk      (clk),
        .rst      (rst),
        .buf_req  (buf_req),
        .buf_line (buf_line),
        .buf_rsp  (buf_rsp),
        .buf_ok   (buf_ok),
        .buf_wr   (buf_wr),
        .busy     (busy)
    );

endmodule

//--- sim/tb_l2_write.sv
`timescale 1ns/10ps

module tb_l2_write;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [7:0]  len;
    } aw_exp_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } w_exp_t;

    logic                    clk;
    logic                    rst;
    logic                    req_w;
    logic                    dma_sign;
    l2_bus_pkg::line_req_t   line;
    logic [3:0]              wstrb;
    l2_bus_pkg::mem_wr_rsp_t mem_rsp;
    logic                    addr_ok_w;
    l2_bus_pkg::mem_wr_t     mem_wr;

    aw_exp_t aw_q[$];
    w_exp_t  w_q[$];
    aw_exp_t aw_head;
    w_exp_t  w_head;
    int      aw_count    = 0;
    int      w_count     = 0;

    logic rst_q     = 1'b1;  // rst one edge late
    logic aw_fire   = 1'b0;
    logic w_fire    = 1'b0;
    logic b_fire    = 1'b0;
    logic line_acc  = 1'b0;
    logic line_open = 1'b0;  // line taken and its response still open
    int   b_count     = 0;
    int   sent_count  = 0;
    int   cycle_count = 0;
    int   num_writes;
    int   timeout_cycles;
    int   rsp_delay;

    l2_write_top DUT (
        .clk       (clk),
        .rst       (rst),
        .req_w     (req_w),
        .dma_sign  (dma_sign),
        .line      (line),
        .wstrb     (wstrb),
        .mem_rsp   (mem_rsp),
        .addr_ok_w (addr_ok_w),
        .mem_wr    (mem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic print_fail_and_stop();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic mismatch_error(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        print_fail_and_stop();
    endtask

    task automatic plain_error(input string why);
        $display("%s", why);
        print_fail_and_stop();
    endtask

    function automatic void refresh_heads();
        aw_count = aw_q.size();
        w_count  = w_q.size();
        aw_head  = (aw_count > 0) ? aw_q[0] : '0;
        w_head   = (w_count > 0) ? w_q[0] : '0;
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #5;
    endtask

    // hold the request until the DUT takes it and release it after the edge
    task automatic wait_accept();
        @(negedge clk);
        while (!addr_ok_w) begin
            @(negedge clk);
        end
        next_drive_slot();
        req_w    = 1'b0;
        dma_sign = 1'b0;
    endtask

    task automatic line_write(input logic [31:0] addr,
                              input logic [l2_cfg_pkg::LINE_BITS-1:0] data);
        aw_exp_t a;
        w_exp_t  w;
        int      i;
        a.addr = addr;
        a.strb = 4'hF;
        a.len  = 8'd3;
        aw_q.push_back(a);
        for (i = 0; i < l2_cfg_pkg::LINE_WORDS; i++) begin
            w.data = data[i*32 +: 32];  // lowest word first
            w.strb = 4'hF;
            w.last = (i == l2_cfg_pkg::LINE_WORDS - 1);
            w_q.push_back(w);
        end
        refresh_heads();
        sent_count++;
        req_w     = 1'b1;
        dma_sign  = 1'b0;
        line.addr = addr;
        line.data = data;
        wstrb     = 4'($urandom);  // ignored for a line
        wait_accept();
    endtask

    task automatic dma_write(input logic [31:0] addr,
                             input logic [l2_cfg_pkg::LINE_BITS-1:0] data,
                             input logic [3:0] strb);
        aw_exp_t a;
        w_exp_t  w;
        a.addr = addr;
        a.strb = strb;
        a.len  = 8'd0;
        w.data = data[31:0];
        w.strb = strb;
        w.last = 1'b1;
        aw_q.push_back(a);
        w_q.push_back(w);
        refresh_heads();
        sent_count++;
        req_w     = 1'b1;
        dma_sign  = 1'b1;
        line.addr = addr;
        line.data = data;
        wstrb     = strb;
        wait_accept();
    endtask

    // memory model answering each phase after 0 to 3 cycles
    initial begin
        mem_rsp   = '0;
        rsp_delay = 0;
        forever begin
            next_drive_slot();
            mem_rsp = '0;
            if (!rst && (mem_wr.wvalid || mem_wr.wwvalid || mem_wr.bready)) begin
                if (rsp_delay == 0) begin
                    mem_rsp.waddr_ok = mem_wr.wvalid;
                    mem_rsp.wready   = mem_wr.wwvalid;
                    mem_rsp.bvalid   = mem_wr.bready;
                    rsp_delay        = $urandom % 4;
                end else begin
                    rsp_delay--;
                end
            end
        end
    end

    always @(negedge clk) begin
        aw_fire  = !rst && mem_wr.wvalid && mem_rsp.waddr_ok;
        w_fire   = !rst && mem_wr.wwvalid && mem_rsp.wready;
        b_fire   = !rst && mem_wr.bready && mem_rsp.bvalid;
        line_acc = !rst && req_w && !dma_sign && addr_ok_w;
    end

    always @(posedge clk) begin
        rst_q <= rst;
        if (aw_fire) begin
            void'(aw_q.pop_front());
        end
        if (w_fire) begin
            void'(w_q.pop_front());
        end
        if (b_fire) begin
            b_count++;
            line_open = 1'b0;
        end
        if (line_acc) begin
            line_open = 1'b1;
        end
        refresh_heads();
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            plain_error("timeout, the writes did not finish within the cycle limit");
        end
    end

    a_aw_pending: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wvalid && mem_rsp.waddr_ok |-> aw_count > 0)
        else plain_error("address phase on the bus with no write pending");
    a_waddr: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wvalid && mem_rsp.waddr_ok |-> mem_wr.waddr == aw_head.addr)
        else mismatch_error("waddr", mem_wr.waddr, aw_head.addr);
    a_len: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wvalid && mem_rsp.waddr_ok |-> mem_wr.len == aw_head.len)
        else mismatch_error("len", 32'(mem_wr.len), 32'(aw_head.len));
    a_aw_strb: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wvalid && mem_rsp.waddr_ok |-> mem_wr.wstrb == aw_head.strb)
        else mismatch_error("wstrb", 32'(mem_wr.wstrb), 32'(aw_head.strb));

    a_w_pending: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wwvalid && mem_rsp.wready |-> w_count > 0)
        else plain_error("data beat on the bus with no beat pending");
    a_wdata: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wwvalid && mem_rsp.wready |-> mem_wr.wdata == w_head.data)
        else mismatch_error("wdata", mem_wr.wdata, w_head.data);
    a_w_strb: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wwvalid && mem_rsp.wready |-> mem_wr.wstrb == w_head.strb)
        else mismatch_error("wstrb", 32'(mem_wr.wstrb), 32'(w_head.strb));
    a_wlast: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wwvalid && mem_rsp.wready |-> mem_wr.wlast == w_head.last)
        else mismatch_error("wlast", 32'(mem_wr.wlast), 32'(w_head.last));

    // uncached ack only rides on the response handshake
    a_dma_ack: assert property (@(negedge clk) disable iff (rst)
        req_w && dma_sign && addr_ok_w |-> mem_rsp.bvalid && mem_wr.bready)
        else plain_error("uncached write acknowledged outside its response handshake");
    a_line_ack: assert property (@(negedge clk) disable iff (rst)
        req_w && !dma_sign && addr_ok_w |-> !line_open)
        else plain_error("line request acknowledged while the previous line was draining");
    a_dma_order: assert property (@(negedge clk) disable iff (rst)
        mem_wr.wvalid && mem_wr.len == 8'd0 |-> !line_open)
        else plain_error("uncached address issued before the line response completed");

    a_reset_quiet: assert property (@(negedge clk)
        rst || rst_q |-> !(mem_wr.wvalid || mem_wr.wwvalid || mem_wr.wlast
                           || mem_wr.bready || addr_ok_w))
        else plain_error("bus or acknowledge active during or right after reset");

    initial begin
        logic [l2_cfg_pkg::LINE_BITS-1:0] data;
        int k;
        void'($urandom(32'h9207_9e39));
        num_writes     = 30;
        timeout_cycles = 20 * num_writes * 12;
        rst      = 1'b1;
        req_w    = 1'b0;
        dma_sign = 1'b0;
        line     = '0;
        wstrb    = 4'h0;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        repeat (2) next_drive_slot();

        for (k = 0; k < num_writes; k++) begin
            data = {$urandom, $urandom, $urandom, $urandom};
            if (k % 3 == 2 || $urandom % 4 == 0) begin
                dma_write($urandom & 32'hFFFF_FFFC, data, 4'($urandom % 15 + 1));
            end else begin
                line_write($urandom & 32'hFFFF_FFF0, data);
            end
            repeat ($urandom % 3) next_drive_slot();  // sometimes back to back
        end

        while (aw_count != 0 || w_count != 0 || line_open) begin
            next_drive_slot();
        end
        repeat (2) next_drive_slot();

        if (b_count == sent_count) begin
            $display("Testbench passed");
            $finish;
        end else begin
            plain_error("number of write responses does not match the writes sent");
        end
    end

endmodule

//--- sources.f
source/l2_cfg_pkg.sv
source/l2_bus_pkg.sv
source/l2_write_ctrl.sv
source/write_buffer.sv
source/write_arbiter.sv
source/l2_write_top.sv
sim/tb_l2_write.sv

//--- run_sim.sh
#!/bin/sh
# build the l2 write path testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_l2_write -o tb_l2_write \
    && ./obj_dir/tb_l2_write | tee /dev/stderr | grep -q "Testbench passed" \
    && { echo "run_sim: simulation ok"; exit 0; } \
    || { echo "run_sim: simulation not ok"; exit 1; }
